/* filelist.f */
src/excl_pkg.sv
src/excl_gnrl_fifo.sv
src/excl_monitor.sv
src/icb_bank_split.sv
src/icb_sram_bank.sv
src/icb_rsp_merge.sv
src/excl_mem_subsys.sv
testbench/tb_excl_mem_subsys.sv

/* src/excl_gnrl_fifo.sv */
/*
 * General synchronous FIFO with valid/ready on both sides.
 * Circular buffer of DP entries, head entry shown while not empty.
 */

`timescale 1ns/10ps

module excl_gnrl_fifo #(
  parameter int DP = 2,
  parameter int DW = 1
) (
  input  logic          i_clk,
  input  logic          i_arst_n,
  input  logic          i_vld,
  output logic          o_rdy,
  input  logic [DW-1:0] i_dat,
  output logic          o_vld,
  input  logic          i_rdy,
  output logic [DW-1:0] o_dat
);

  localparam int PW = (DP > 1) ? $clog2(DP) : 1;
  localparam int CW = $clog2(DP + 1);

  logic [DW-1:0] mem [DP];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] cnt;
  logic          push;
  logic          pop;

  assign push  = i_vld & o_rdy;
  assign pop   = o_vld & i_rdy;
  assign o_rdy = (cnt != CW'(DP));
  assign o_vld = (cnt != '0);
  assign o_dat = mem[rd_ptr];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(DP - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DP - 1)) ? '0 : rd_ptr + 1'b1;
      end
      cnt <= cnt + CW'(push) - CW'(pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_dat;
    end
  end

  a_cnt_bound: assert property (@(posedge i_clk) disable iff (!i_arst_n) cnt <= CW'(DP))
    else $error("FIFO count above depth");

endmodule

/* src/excl_mem_subsys.sv */
/*
 * Memory subsystem with load-reserved / store-conditional support.
 * Exclusive monitor, bank splitter, interleaved SRAM banks and an
 * in-order response merger.
 */

`timescale 1ns/10ps

module excl_mem_subsys import excl_pkg::*; #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 16,
  parameter int OUTS_DEPTH = 2
) (
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  logic     i_icb_cmd_valid,
  output logic     o_icb_cmd_ready,
  input  icb_cmd_t i_icb_cmd,
  input  logic     i_icb_cmd_excl,
  output logic     o_icb_rsp_valid,
  input  logic     i_icb_rsp_ready,
  output icb_rsp_t o_icb_rsp,
  output logic     o_icb_rsp_excl_ok
);

  logic                 mon_cmd_valid;
  logic                 mon_cmd_ready;
  icb_cmd_t             mon_cmd;
  logic [NUM_BANKS-1:0] bank_valid;
  logic [NUM_BANKS-1:0] bank_ready;
  icb_cmd_t             bank_cmd;
  logic                 issue_valid;
  logic                 issue_ready;
  bank_id_t             issue_bank;
  logic [NUM_BANKS-1:0] bank_rsp_valid;
  logic [NUM_BANKS-1:0] bank_rsp_ready;
  icb_rsp_t             bank_rsp [NUM_BANKS];
  logic                 mrg_rsp_valid;
  logic                 mrg_rsp_ready;
  icb_rsp_t             mrg_rsp;

  excl_monitor #(
    .OUTS_DEPTH (OUTS_DEPTH)
  ) u_monitor (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_cmd_valid   (i_icb_cmd_valid),
    .o_cmd_ready   (o_icb_cmd_ready),
    .i_cmd         (i_icb_cmd),
    .i_cmd_excl    (i_icb_cmd_excl),
    .o_cmd_valid   (mon_cmd_valid),
    .i_cmd_ready   (mon_cmd_ready),
    .o_cmd         (mon_cmd),
    .i_rsp_valid   (mrg_rsp_valid),
    .o_rsp_ready   (mrg_rsp_ready),
    .i_rsp         (mrg_rsp),
    .o_rsp_valid   (o_icb_rsp_valid),
    .i_rsp_ready   (i_icb_rsp_ready),
    .o_rsp         (o_icb_rsp),
    .o_rsp_excl_ok (o_icb_rsp_excl_ok)
  );

  icb_bank_split #(
    .NUM_BANKS (NUM_BANKS)
  ) u_split (
    .i_cmd_valid   (mon_cmd_valid),
    .o_cmd_ready   (mon_cmd_ready),
    .i_cmd         (mon_cmd),
    .o_bank_valid  (bank_valid),
    .i_bank_ready  (bank_ready),
    .o_bank_cmd    (bank_cmd),
    .o_issue_valid (issue_valid),
    .i_issue_ready (issue_ready),
    .o_issue_bank  (issue_bank)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    icb_sram_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) u_bank (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_cmd_valid (bank_valid[k]),
      .o_cmd_ready (bank_ready[k]),
      .i_cmd       (bank_cmd),
      .o_rsp_valid (bank_rsp_valid[k]),
      .i_rsp_ready (bank_rsp_ready[k]),
      .o_rsp       (bank_rsp[k])
    );
  end

  icb_rsp_merge #(
    .NUM_BANKS  (NUM_BANKS),
    .OUTS_DEPTH (OUTS_DEPTH)
  ) u_merge (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_issue_valid    (issue_valid),
    .o_issue_ready    (issue_ready),
    .i_issue_bank     (issue_bank),
    .i_bank_rsp_valid (bank_rsp_valid),
    .o_bank_rsp_ready (bank_rsp_ready),
    .i_bank_rsp       (bank_rsp),
    .o_rsp_valid      (mrg_rsp_valid),
    .i_rsp_ready      (mrg_rsp_ready),
    .o_rsp            (mrg_rsp)
  );

endmodule

/* src/excl_monitor.sv */
/*
 * Exclusive-access monitor.
 * Keeps one reservation, masks failed store-conditionals and
 * returns the exclusive-okay bit with each response.
 */

`timescale 1ns/10ps

module excl_monitor import excl_pkg::*; #(
  parameter int OUTS_DEPTH = 2
) (
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  logic     i_cmd_valid,
  output logic     o_cmd_ready,
  input  icb_cmd_t i_cmd,
  input  logic     i_cmd_excl,
  output logic     o_cmd_valid,
  input  logic     i_cmd_ready,
  output icb_cmd_t o_cmd,
  input  logic     i_rsp_valid,
  output logic     o_rsp_ready,
  input  icb_rsp_t i_rsp,
  output logic     o_rsp_valid,
  input  logic     i_rsp_ready,
  output icb_rsp_t o_rsp,
  output logic     o_rsp_excl_ok
);

  logic  excl_flg_r;
  addr_t excl_addr_r;
  logic  addr_eq;
  logic  cmd_hsk;
  logic  rsp_hsk;
  logic  flg_set;
  logic  flg_clr;
  logic  is_scond;
  logic  scond_ok;
  logic  fifo_i_rdy;
  logic  fifo_o_vld;
  logic  fifo_o_dat;

  assign addr_eq = (i_cmd.addr == excl_addr_r);
  assign cmd_hsk = i_cmd_valid & o_cmd_ready;
  assign rsp_hsk = i_rsp_valid & i_rsp_ready;

  // Exclusive read reserves, any write to the reserved address clears.
  assign flg_set = cmd_hsk & i_cmd.read & i_cmd_excl;
  assign flg_clr = cmd_hsk & ~i_cmd.read & addr_eq & excl_flg_r;

  assign is_scond = i_cmd_excl & ~i_cmd.read;
  assign scond_ok = is_scond & addr_eq & excl_flg_r;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      excl_flg_r <= 1'b0;
    end else if (flg_set) begin
      excl_flg_r <= 1'b1;
    end else if (flg_clr) begin
      excl_flg_r <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (flg_set) begin
      excl_addr_r <= i_cmd.addr;
    end
  end

  // Command path, gated on room for the success bit.
  assign o_cmd_valid = i_cmd_valid & fifo_i_rdy;
  assign o_cmd_ready = i_cmd_ready & fifo_i_rdy;
  always_comb begin
    o_cmd = i_cmd;
    if (is_scond && !scond_ok) begin
      o_cmd.wmask = '0;
    end
  end

  excl_gnrl_fifo #(
    .DP (OUTS_DEPTH),
    .DW (1)
  ) u_excl_fifo (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_vld    (cmd_hsk),
    .o_rdy    (fifo_i_rdy),
    .i_dat    (scond_ok),
    .o_vld    (fifo_o_vld),
    .i_rdy    (rsp_hsk),
    .o_dat    (fifo_o_dat)
  );

  assign o_rsp_valid   = i_rsp_valid;
  assign o_rsp         = i_rsp;
  assign o_rsp_ready   = i_rsp_ready;
  assign o_rsp_excl_ok = fifo_o_vld & fifo_o_dat;

  a_rsp_has_cmd: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rsp_valid |-> fifo_o_vld)
    else $error("Response without an outstanding command");

endmodule

/* src/excl_pkg.sv */
/*
 * Shared definitions for the exclusive-access memory subsystem.
 * Bus widths, vector types and the ICB command and response structs.
 */

package excl_pkg;

  // Bus widths.
  localparam int PA_SIZE = 32;
  localparam int MLEN    = 32;

  typedef logic [PA_SIZE-1:0] addr_t;
  typedef logic [MLEN-1:0]    data_t;
  typedef logic [MLEN/8-1:0]  wmask_t;
  typedef logic [1:0]         size_t;

  // Up to four banks.
  typedef logic [1:0]         bank_id_t;

  // Downstream command, 72 bits.
  typedef struct packed {
    addr_t  addr;
    logic   read;
    data_t  wdata;
    wmask_t wmask;
    logic   lock;
    size_t  size;
  } icb_cmd_t;

  // Response, 33 bits.
  typedef struct packed {
    data_t rdata;
    logic  err;
  } icb_rsp_t;

endpackage

/* src/icb_bank_split.sv */
/*
 * Bank splitter.
 * Decodes the word-interleaved bank of each command, forwards it with a
 * bank-local index and announces the bank to the response merger.
 */

`timescale 1ns/10ps

module icb_bank_split import excl_pkg::*; #(
  parameter int NUM_BANKS = 4
) (
  input  logic                 i_cmd_valid,
  output logic                 o_cmd_ready,
  input  icb_cmd_t             i_cmd,
  output logic [NUM_BANKS-1:0] o_bank_valid,
  input  logic [NUM_BANKS-1:0] i_bank_ready,
  output icb_cmd_t             o_bank_cmd,
  output logic                 o_issue_valid,
  input  logic                 i_issue_ready,
  output bank_id_t             o_issue_bank
);

  logic [PA_SIZE-3:0] word_addr;
  bank_id_t           bank;
  logic               bank_rdy;

  assign word_addr = i_cmd.addr[PA_SIZE-1:2];
  assign bank      = bank_id_t'(word_addr % NUM_BANKS);

  always_comb begin
    bank_rdy = 1'b0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      if (bank == bank_id_t'(k)) begin
        bank_rdy = i_bank_ready[k];
      end
    end
  end

  // Bank sees the command only while the merger can take the record.
  always_comb begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      o_bank_valid[k] = i_cmd_valid & i_issue_ready & (bank == bank_id_t'(k));
    end
  end

  always_comb begin
    o_bank_cmd      = i_cmd;
    o_bank_cmd.addr = addr_t'(word_addr / NUM_BANKS);
  end

  assign o_cmd_ready   = i_issue_ready & bank_rdy;
  assign o_issue_valid = i_cmd_valid & bank_rdy;
  assign o_issue_bank  = bank;

  always_comb begin
    a_bank_onehot: assert final ($onehot0(o_bank_valid))
      else $error("More than one bank selected");
  end

endmodule

/* src/icb_rsp_merge.sv */
/*
 * Response merger.
 * Records the bank of each issued command and returns bank responses
 * in that order.
 */

`timescale 1ns/10ps

module icb_rsp_merge import excl_pkg::*; #(
  parameter int NUM_BANKS  = 4,
  parameter int OUTS_DEPTH = 2
) (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_issue_valid,
  output logic                 o_issue_ready,
  input  bank_id_t             i_issue_bank,
  input  logic [NUM_BANKS-1:0] i_bank_rsp_valid,
  output logic [NUM_BANKS-1:0] o_bank_rsp_ready,
  input  icb_rsp_t             i_bank_rsp [NUM_BANKS],
  output logic                 o_rsp_valid,
  input  logic                 i_rsp_ready,
  output icb_rsp_t             o_rsp
);

  logic     head_vld;
  bank_id_t head;
  logic     rsp_hsk;

  excl_gnrl_fifo #(
    .DP (OUTS_DEPTH),
    .DW ($bits(bank_id_t))
  ) u_order_fifo (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_vld    (i_issue_valid),
    .o_rdy    (o_issue_ready),
    .i_dat    (i_issue_bank),
    .o_vld    (head_vld),
    .i_rdy    (rsp_hsk),
    .o_dat    (head)
  );

  // Only the bank at the head is drained.
  always_comb begin
    o_rsp_valid = 1'b0;
    o_rsp       = '0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      o_bank_rsp_ready[k] = head_vld & (head == bank_id_t'(k)) & i_rsp_ready;
      if (head_vld && head == bank_id_t'(k)) begin
        o_rsp_valid = i_bank_rsp_valid[k];
        o_rsp       = i_bank_rsp[k];
      end
    end
  end

  assign rsp_hsk = o_rsp_valid & i_rsp_ready;

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_chk
    a_rsp_has_issue: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_bank_rsp_valid[k] |-> head_vld)
      else $error("Bank response with no issue record");
  end

endmodule

/* src/icb_sram_bank.sv */
/*
 * One word-wide SRAM bank.
 * Byte-masked writes, index range check and a response register that
 * holds until it transfers.
 */

`timescale 1ns/10ps

module icb_sram_bank import excl_pkg::*; #(
  parameter int BANK_WORDS = 16
) (
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  logic     i_cmd_valid,
  output logic     o_cmd_ready,
  input  icb_cmd_t i_cmd,
  output logic     o_rsp_valid,
  input  logic     i_rsp_ready,
  output icb_rsp_t o_rsp
);

  localparam int IW = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  data_t    mem [BANK_WORDS];
  logic     cmd_hsk;
  logic     in_range;
  logic     [IW-1:0] idx;
  logic     rsp_vld_r;
  icb_rsp_t rsp_r;

  assign in_range    = (i_cmd.addr < addr_t'(BANK_WORDS));
  assign idx         = i_cmd.addr[IW-1:0];
  assign o_cmd_ready = ~rsp_vld_r | i_rsp_ready;
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;

  // Contents start at zero.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (cmd_hsk && !i_cmd.read && in_range) begin
      for (int b = 0; b < MLEN / 8; b++) begin
        if (i_cmd.wmask[b]) begin
          mem[idx][8*b +: 8] <= i_cmd.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rsp_vld_r <= 1'b0;
    end else if (cmd_hsk) begin
      rsp_vld_r <= 1'b1;
    end else if (i_rsp_ready) begin
      rsp_vld_r <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_hsk) begin
      rsp_r.rdata <= (i_cmd.read && in_range) ? mem[idx] : '0;
      rsp_r.err   <= ~in_range;
    end
  end

  assign o_rsp_valid = rsp_vld_r;
  assign o_rsp       = rsp_r;

endmodule

/* testbench/tb_excl_mem_subsys.sv */
/*
 * Testbench for the exclusive-access memory subsystem.
 * Directed and random traffic, checked against a memory and reservation model.
 */

`timescale 1ns/10ps

module tb_excl_mem_subsys import excl_pkg::*; ();

  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 16;
  localparam int OUTS_DEPTH = 2;
  localparam int NUM_WORDS  = NUM_BANKS * BANK_WORDS;

  typedef struct packed {
    icb_rsp_t rsp;
    logic     excl_ok;
  } exp_t;

  logic     i_clk;
  logic     i_arst_n;
  logic     i_icb_cmd_valid;
  logic     o_icb_cmd_ready;
  icb_cmd_t i_icb_cmd;
  logic     i_icb_cmd_excl;
  logic     o_icb_rsp_valid;
  logic     i_icb_rsp_ready;
  icb_rsp_t o_icb_rsp;
  logic     o_icb_rsp_excl_ok;

  data_t    mem_model [NUM_WORDS];
  logic     resv_flg;
  addr_t    resv_addr;
  exp_t     exp_q [$];
  exp_t     exp_head;
  int       exp_cnt;
  logic     cmd_fire_n;
  logic     rsp_fire_n;
  logic     rsp_rand_en;
  int       n_issued;
  int       cycle_cnt;

  excl_mem_subsys UUT (.*);

  always #50 i_clk = ~i_clk;

  // Handshakes sampled mid-cycle, where every signal has settled.
  always @(negedge i_clk) begin
    cmd_fire_n <= i_icb_cmd_valid & o_icb_cmd_ready;
    rsp_fire_n <= o_icb_rsp_valid & i_icb_rsp_ready;
  end

  always @(posedge i_clk) begin : drive_rsp_ready
    logic rand_on;
    rand_on = rsp_rand_en;
    #1;
    i_icb_rsp_ready = rand_on ? (($urandom % 3) != 0) : 1'b1;
  end

  task automatic report_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
    $display("FAILED %s expected %0h actual %0h", name, exp, act);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_text(input string what);
    $display("ERROR: %s", what);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  // Reference model, applied in command order.
  function automatic exp_t predict(icb_cmd_t cmd, logic excl);
    exp_t        e;
    logic [29:0] word;
    logic        in_rng;
    logic        scond;
    logic        ok;
    word          = cmd.addr[PA_SIZE-1:2];
    in_rng        = (word / NUM_BANKS) < BANK_WORDS;
    scond         = excl & ~cmd.read;
    ok            = scond & resv_flg & (cmd.addr == resv_addr);
    e.rsp.err     = ~in_rng;
    e.rsp.rdata   = (cmd.read && in_rng) ? mem_model[word] : '0;
    e.excl_ok     = ok;
    if (!cmd.read && in_rng && (!scond || ok)) begin
      for (int b = 0; b < 4; b++) begin
        if (cmd.wmask[b]) begin
          mem_model[word][8*b +: 8] = cmd.wdata[8*b +: 8];
        end
      end
    end
    if (cmd.read && excl) begin
      resv_flg  = 1'b1;
      resv_addr = cmd.addr;
    end else if (!cmd.read && resv_flg && cmd.addr == resv_addr) begin
      resv_flg = 1'b0;
    end
    return e;
  endfunction

  always @(posedge i_clk) begin
    if (rsp_fire_n && exp_q.size() != 0) begin
      exp_q.delete(0);
    end
    if (cmd_fire_n) begin
      exp_q.push_back(predict(i_icb_cmd, i_icb_cmd_excl));
    end
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  end

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt > 20 * n_issued + 100) begin
      $display("Timeout after %0d cycles, responses stopped arriving", cycle_cnt);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  a_rsp_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_icb_rsp_valid |-> exp_cnt != 0)
    else report_text("response arrived with no command outstanding");

  a_rsp_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_icb_rsp_valid && i_icb_rsp_ready |-> o_icb_rsp == exp_head.rsp)
    else report_value("o_icb_rsp", $sampled(exp_head.rsp), $sampled(o_icb_rsp));

  a_excl_ok: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_icb_rsp_valid && i_icb_rsp_ready |-> o_icb_rsp_excl_ok == exp_head.excl_ok)
    else report_value("o_icb_rsp_excl_ok", $sampled(exp_head.excl_ok),
                      $sampled(o_icb_rsp_excl_ok));

  a_rsp_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_icb_rsp_valid && !i_icb_rsp_ready |=>
      o_icb_rsp_valid && $stable(o_icb_rsp) && $stable(o_icb_rsp_excl_ok))
    else report_text("response dropped or changed while stalled");

  a_outstanding: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    exp_cnt <= OUTS_DEPTH)
    else report_text("more commands accepted than allowed outstanding");

  task automatic send_cmd(input icb_cmd_t cmd, input logic excl);
    i_icb_cmd_valid = 1'b1;
    i_icb_cmd       = cmd;
    i_icb_cmd_excl  = excl;
    n_issued++;
    do begin
      @(posedge i_clk);
    end while (!cmd_fire_n);
    #1;
    i_icb_cmd_valid = 1'b0;
    i_icb_cmd_excl  = 1'b0;
  endtask

  task automatic write_word(input addr_t addr, input data_t data, input wmask_t mask,
                            input logic excl);
    send_cmd('{addr: addr, read: 1'b0, wdata: data, wmask: mask, lock: 1'b0,
               size: 2'b10}, excl);
  endtask

  task automatic read_word(input addr_t addr, input logic excl);
    send_cmd('{addr: addr, read: 1'b1, wdata: '0, wmask: '0, lock: 1'b0,
               size: 2'b10}, excl);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge i_clk);
    #1;
  endtask

  task automatic drain();
    while (exp_cnt != 0) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  initial begin
    icb_cmd_t c;
    logic     excl;
    void'($urandom(32'h140f69f6));
    i_clk = 1'b0;
    i_arst_n = 1'b0;
    i_icb_cmd_valid = 1'b0;
    i_icb_cmd = '0;
    i_icb_cmd_excl = 1'b0;
    i_icb_rsp_ready = 1'b1;
    cmd_fire_n = 1'b0;
    rsp_fire_n = 1'b0;
    rsp_rand_en = 1'b0;
    resv_flg = 1'b0;
    resv_addr = '0;
    exp_cnt = 0;
    exp_head = '0;
    n_issued = 0;
    cycle_cnt = 0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      mem_model[w] = '0;
    end
    repeat (5) @(posedge i_clk);
    #1;
    i_arst_n = 1'b1;
    idle_cycles(2);

    // Partial byte masks across all banks.
    for (int w = 0; w < 8; w++) begin
      write_word(addr_t'(w * 4), 32'h11223344 ^ data_t'(w), 4'b0101, 1'b0);
      write_word(addr_t'(w * 4), 32'hA0B0C0D0 + data_t'(w), 4'b1010, 1'b0);
    end
    for (int w = 0; w < 8; w++) begin
      read_word(addr_t'(w * 4), 1'b0);
    end

    // Reservation then store-conditional, then a second one that fails.
    read_word(32'h24, 1'b1);
    write_word(32'h24, 32'hCAFE0001, 4'hF, 1'b1);
    read_word(32'h24, 1'b0);
    write_word(32'h24, 32'hCAFE0002, 4'hF, 1'b1);
    read_word(32'h24, 1'b0);

    // Plain write breaks the reservation.
    read_word(32'h28, 1'b1);
    write_word(32'h28, 32'h5A5A5A5A, 4'hF, 1'b0);
    write_word(32'h28, 32'hDEADBEEF, 4'hF, 1'b1);
    read_word(32'h28, 1'b0);
    write_word(32'h2C, 32'h0BAD0BAD, 4'hF, 1'b1);
    read_word(32'h2C, 1'b0);
    read_word(32'h30, 1'b1);
    write_word(32'h34, 32'h12345678, 4'hF, 1'b1);
    read_word(32'h34, 1'b0);
    write_word(32'h30, 32'h87654321, 4'hF, 1'b1);
    read_word(32'h30, 1'b0);

    // Out of range, then every valid word read back.
    write_word(32'h100, 32'hFFFFFFFF, 4'hF, 1'b0);
    read_word(32'h100, 1'b0);
    write_word(32'h1FC, 32'hFFFFFFFF, 4'hF, 1'b0);
    for (int w = 0; w < NUM_WORDS; w++) begin
      read_word(addr_t'(w * 4), 1'b0);
    end
    drain();

    // Random traffic with random response back-pressure.
    rsp_rand_en = 1'b1;
    for (int n = 0; n < 200; n++) begin
      c.addr  = ($urandom % 2) ? addr_t'(($urandom % 4) << 2)
                               : addr_t'(($urandom % (NUM_WORDS + 4)) << 2);
      c.read  = $urandom % 2;
      c.wdata = $urandom;
      c.wmask = wmask_t'($urandom);
      c.lock  = $urandom % 2;
      c.size  = size_t'($urandom);
      excl    = ($urandom % 4) == 0;
      send_cmd(c, excl);
      if (($urandom % 4) == 0) begin
        idle_cycles(($urandom % 3) + 1);
      end
    end
    drain();
    rsp_rand_en = 1'b0;
    idle_cycles(5);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
